// ==== list.f ====
+incdir+tb
hdl/eib_pkg.sv
hdl/eib_bus_decode.sv
hdl/eib_nest_stack.sv
hdl/eib_irq_status.sv
hdl/eib_read_result.sv
hdl/eib_top.sv
tb/tb_eib.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_eib -f list.f -o tb_eib_sim

status=0
./obj_dir/tb_eib_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Simulation failed" sim.log; then
    echo "run.sh: testbench reported a failure"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "run.sh: simulator exited with status $status"
    exit 1
fi
echo "run.sh: done"

// ==== tb/eib_vectors.svh ====
// stimulus and expected-value table for the interrupt block testbench
// columns: action, random flag, addr, data, expected rdata, expected trap
`ifndef EIB_VECTORS_SVH
`define EIB_VECTORS_SVH

task automatic build_table();
    // values after reset
    add_row(ACT_READ,  1'b0, 32'hffff_fffd, 32'h0000_0000, 32'hffff_ffff, 1'b0);
    add_row(ACT_READ,  1'b0, 32'hffff_fffe, 32'h0000_0000, 32'h0000_0000, 1'b0);
    // trap from irq line 4, then masked off
    add_row(ACT_IRQ,   1'b0, 32'h0000_0000, 32'h0000_0010, 32'h0000_0000, 1'b1);
    add_row(ACT_READ,  1'b0, 32'hffff_fffe, 32'h0000_0000, 32'h0000_0010, 1'b1);
    add_row(ACT_WRITE, 1'b0, 32'hffff_fffd, 32'hffff_ffef, 32'h0000_0000, 1'b0);
    add_row(ACT_READ,  1'b0, 32'hffff_fffd, 32'h0000_0000, 32'hffff_ffef, 1'b0);
    add_row(ACT_WRITE, 1'b0, 32'hffff_fffd, 32'hffff_ffff, 32'h0000_0000, 1'b1);
    add_row(ACT_IRQ,   1'b0, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 1'b0);
    add_row(ACT_READ,  1'b0, 32'hffff_fffe, 32'h0000_0000, 32'h0000_0000, 1'b0);
    // decode filtering at level 0
    add_row(ACT_WRITE, 1'b0, 32'hffff_fffd, 32'h0000_a5a5, 32'h0000_0000, 1'b0);
    add_row(ACT_WRITE, 1'b0, 32'hffff_effd, 32'h0000_0000, 32'h0000_0000, 1'b0);
    add_row(ACT_WRITE, 1'b0, 32'h0000_0ffd, 32'h0000_0000, 32'h0000_0000, 1'b0);
    add_row(ACT_READ,  1'b0, 32'hffff_fffd, 32'h0000_0000, 32'h0000_a5a5, 1'b0);
    add_row(ACT_WRITE, 1'b0, 32'hffff_ffc3, 32'h1234_5678, 32'h0000_0000, 1'b0);
    add_row(ACT_WRITE, 1'b0, 32'hffff_efc3, 32'hdead_beef, 32'h0000_0000, 1'b0);
    add_row(ACT_WRITE, 1'b0, 32'hffff_ffa3, 32'hdead_beef, 32'h0000_0000, 1'b0);
    add_row(ACT_WRITE, 1'b0, 32'hffff_ffe3, 32'hdead_beef, 32'h0000_0000, 1'b0);
    add_row(ACT_WRITE, 1'b0, 32'hffff_f003, 32'hdead_beef, 32'h0000_0000, 1'b0);
    add_row(ACT_READ,  1'b0, 32'hffff_ffc3, 32'h0000_0000, 32'h1234_5678, 1'b0);
    add_row(ACT_READ,  1'b0, 32'h0000_0ffe, 32'h0000_0000, 32'h1234_5678, 1'b0);
    // nesting with fixed return addresses and masks
    add_row(ACT_WRITE, 1'b0, 32'hffff_ffff, 32'h0000_1000, 32'h0000_0000, 1'b0);
    add_row(ACT_READ,  1'b0, 32'hffff_fffd, 32'h0000_0000, 32'h0000_a5a5, 1'b0);
    add_row(ACT_WRITE, 1'b0, 32'hffff_fffd, 32'h0000_0f0f, 32'h0000_0000, 1'b0);
    add_row(ACT_READ,  1'b0, 32'hffff_fffd, 32'h0000_0000, 32'h0000_0f0f, 1'b0);
    add_row(ACT_WRITE, 1'b0, 32'hffff_ffff, 32'h0000_2000, 32'h0000_0000, 1'b0);
    add_row(ACT_WRITE, 1'b0, 32'hffff_fffd, 32'h0000_00ff, 32'h0000_0000, 1'b0);
    add_row(ACT_READ,  1'b0, 32'hffff_fffd, 32'h0000_0000, 32'h0000_00ff, 1'b0);
    add_row(ACT_WRITE, 1'b0, 32'hffff_ffff, 32'h0000_3000, 32'h0000_0000, 1'b0);
    add_row(ACT_WRITE, 1'b0, 32'hffff_fffd, 32'h0000_0001, 32'h0000_0000, 1'b0);
    add_row(ACT_READ,  1'b0, 32'hffff_fffd, 32'h0000_0000, 32'h0000_0001, 1'b0);
    add_row(ACT_READ,  1'b0, 32'hffff_ffff, 32'h0000_0000, 32'h0000_3000, 1'b0);
    add_row(ACT_READ,  1'b0, 32'hffff_fffd, 32'h0000_0000, 32'h0000_00ff, 1'b0);
    add_row(ACT_READ,  1'b0, 32'hffff_ffff, 32'h0000_0000, 32'h0000_2000, 1'b0);
    add_row(ACT_READ,  1'b0, 32'hffff_fffd, 32'h0000_0000, 32'h0000_0f0f, 1'b0);
    add_row(ACT_READ,  1'b0, 32'hffff_ffff, 32'h0000_0000, 32'h0000_1000, 1'b0);
    add_row(ACT_READ,  1'b0, 32'hffff_fffd, 32'h0000_0000, 32'h0000_a5a5, 1'b0);
    // random scratch words and masks, expectations from the model
    add_row(ACT_WRITE, 1'b1, 32'hffff_fffd, 32'h0000_0000, 32'h0000_0000, 1'b0);
    add_row(ACT_WRITE, 1'b1, 32'hffff_ffc0, 32'h0000_0000, 32'h0000_0000, 1'b0);
    add_row(ACT_WRITE, 1'b1, 32'hffff_ffc7, 32'h0000_0000, 32'h0000_0000, 1'b0);
    add_row(ACT_WRITE, 1'b1, 32'hffff_ffdf, 32'h0000_0000, 32'h0000_0000, 1'b0);
    add_row(ACT_WRITE, 1'b1, 32'hffff_ffff, 32'h0000_0000, 32'h0000_0000, 1'b0);
    add_row(ACT_WRITE, 1'b1, 32'hffff_fffd, 32'h0000_0000, 32'h0000_0000, 1'b0);
    add_row(ACT_WRITE, 1'b1, 32'hffff_ffc0, 32'h0000_0000, 32'h0000_0000, 1'b0);
    add_row(ACT_WRITE, 1'b1, 32'hffff_ffc7, 32'h0000_0000, 32'h0000_0000, 1'b0);
    add_row(ACT_WRITE, 1'b1, 32'hffff_ffdf, 32'h0000_0000, 32'h0000_0000, 1'b0);
    add_row(ACT_READ,  1'b1, 32'hffff_ffc7, 32'h0000_0000, 32'h0000_0000, 1'b0);
    add_row(ACT_READ,  1'b1, 32'hffff_fffd, 32'h0000_0000, 32'h0000_0000, 1'b0);
    add_row(ACT_READ,  1'b1, 32'hffff_ffff, 32'h0000_0000, 32'h0000_0000, 1'b0);
    add_row(ACT_READ,  1'b1, 32'hffff_fffd, 32'h0000_0000, 32'h0000_0000, 1'b0);
    add_row(ACT_READ,  1'b1, 32'hffff_ffc0, 32'h0000_0000, 32'h0000_0000, 1'b0);
    add_row(ACT_READ,  1'b1, 32'hffff_ffc7, 32'h0000_0000, 32'h0000_0000, 1'b0);
    add_row(ACT_READ,  1'b1, 32'hffff_ffdf, 32'h0000_0000, 32'h0000_0000, 1'b0);
    add_row(ACT_READ,  1'b1, 32'hffff_ffc3, 32'h0000_0000, 32'h0000_0000, 1'b0);
    add_row(ACT_IDLE,  1'b0, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 1'b0);
endtask

`endif

// ==== tb/tb_eib.sv ====
// testbench for the external interrupt block
// table loop with a small reference model, check task and watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_eib;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 16;
    localparam int ROW_CYCLES   = 4;        // drive, release, two pipeline edges

    typedef enum logic [1:0] {
        ACT_IDLE,
        ACT_WRITE,
        ACT_READ,
        ACT_IRQ
    } action_e;

    typedef struct packed {
        action_e        act;
        logic           rnd;        // data from $random, expectation from the model
        eib_pkg::word_t addr;
        eib_pkg::word_t data;
        eib_pkg::word_t exp_rdata;  // used on read rows only
        logic           exp_trap;
    } row_t;

    logic              clk;
    logic              reset_n;
    logic              strobe;
    logic              rw;
    eib_pkg::word_t    addr;
    eib_pkg::word_t    wdata;
    eib_pkg::irq_vec_t irq;
    eib_pkg::word_t    rdata;
    logic              trap;

    row_t              rows [$];
    integer            seed;

    // reference model state
    int                model_depth;
    eib_pkg::irq_vec_t model_mask    [32];
    eib_pkg::word_t    model_ret     [32];
    eib_pkg::word_t    model_scratch [32][32];
    eib_pkg::word_t    model_rdata;
    eib_pkg::irq_vec_t irq_level;
    eib_pkg::word_t    last_rdata;      // rdata holds the last read value

    eib_top u_dut (
        .clk     (clk),
        .reset_n (reset_n),
        .strobe  (strobe),
        .rw      (rw),
        .addr    (addr),
        .wdata   (wdata),
        .irq     (irq),
        .rdata   (rdata),
        .trap    (trap)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input eib_pkg::word_t got,
                               input eib_pkg::word_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic add_row(input action_e act, input logic rnd, input eib_pkg::word_t a,
                           input eib_pkg::word_t d, input eib_pkg::word_t exp_rdata,
                           input logic exp_trap);
        row_t row;
        row.act       = act;
        row.rnd       = rnd;
        row.addr      = a;
        row.data      = d;
        row.exp_rdata = exp_rdata;
        row.exp_trap  = exp_trap;
        rows.push_back(row);
    endtask

    `include "eib_vectors.svh"

    // bus access as software sees it, page ffff_f000
    task automatic model_access(input logic write, input eib_pkg::word_t a,
                                input eib_pkg::word_t d);
        if (a[31:12] == 20'hfffff) begin
            if (a[11:0] == 12'hfff) begin
                if (write) begin
                    model_depth                = model_depth + 1;
                    model_ret[model_depth]     = d;
                    model_mask[model_depth]    = model_mask[model_depth - 1];
                end else begin
                    model_rdata = model_ret[model_depth];
                    model_depth = model_depth - 1;
                end
            end else if (a[11:0] == 12'hffe) begin
                if (!write)
                    model_rdata = irq_level;    // lines are levels
            end else if (a[11:0] == 12'hffd) begin
                if (write)
                    model_mask[model_depth] = d;
                else
                    model_rdata = model_mask[model_depth];
            end else if (a >= 32'hffff_ffc0 && a <= 32'hffff_ffdf) begin
                if (write)
                    model_scratch[model_depth][a[4:0]] = d;
                else
                    model_rdata = model_scratch[model_depth][a[4:0]];
            end
        end
    endtask

    task automatic apply_row(input int idx, input row_t row);
        eib_pkg::word_t data;
        data = row.data;
        if (row.rnd && row.act == ACT_WRITE)
            data = $random(seed);
        @(posedge clk);
        case (row.act)
            ACT_WRITE, ACT_READ: begin
                strobe <= 1'b1;
                rw     <= (row.act == ACT_WRITE);
                addr   <= row.addr;
                wdata  <= data;
                model_access(row.act == ACT_WRITE, row.addr, data);
            end
            ACT_IRQ: begin
                irq       <= data;
                irq_level  = data;
            end
            default: begin
            end
        endcase
        if (row.act == ACT_READ)
            last_rdata = row.rnd ? model_rdata : row.exp_rdata;
        @(posedge clk);
        strobe <= 1'b0;                 // single cycle access
        @(posedge clk);
        @(posedge clk);
        @(negedge clk);                 // rdata and trap settled
        check_value($sformatf("rdata row %0d", idx), rdata, last_rdata);
        check_value($sformatf("trap row %0d", idx), eib_pkg::word_t'(trap),
                    eib_pkg::word_t'(row.exp_trap));
    endtask

    initial begin
        clk         = 1'b0;
        reset_n     = 1'b0;
        strobe      = 1'b0;
        rw          = 1'b0;
        addr        = '0;
        wdata       = '0;
        irq         = '0;
        seed        = 32'h0db6_4ccb;
        irq_level   = '0;
        model_depth = 0;
        model_mask[0] = '1;
        model_rdata = '0;
        last_rdata  = '0;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        reset_n <= 1'b1;
        for (int i = 0; i < rows.size(); i++)
            apply_row(i, rows[i]);
        $display("Simulation passed");
        $finish;
    end

    // watchdog, sized from the table length
    initial begin
        #1;
        #((rows.size() + 20) * CLK_PERIOD * ROW_CYCLES);
        $display("Timeout: the stimulus table did not complete in time");
        $display("Simulation failed");
        $fatal(1, "watchdog timeout");
    end

endmodule

`default_nettype wire

// ==== hdl/eib_top.sv ====
// top level of the external interrupt block
// decode, execute (nesting and status) and result stages
`timescale 1ns/1ps
`default_nettype none

module eib_top (
    input  wire logic               clk,
    input  wire logic               reset_n,
    input  wire logic               strobe,
    input  wire logic               rw,
    input  wire eib_pkg::word_t     addr,
    input  wire eib_pkg::word_t     wdata,
    input  wire eib_pkg::irq_vec_t  irq,
    output eib_pkg::word_t          rdata,
    output logic                    trap
);

    eib_pkg::bus_op_t  op;
    eib_pkg::depth_t   depth;
    eib_pkg::irq_vec_t cur_mask;
    eib_pkg::irq_vec_t isr;
    eib_pkg::word_t    ra_out;
    eib_pkg::word_t    stk_out;

    eib_bus_decode u_decode (
        .clk      (clk),
        .reset_n  (reset_n),
        .strobe   (strobe),
        .rw       (rw),
        .addr     (addr),
        .wdata    (wdata),
        .op       (op)
    );

    eib_nest_stack u_nest (
        .clk      (clk),
        .reset_n  (reset_n),
        .op       (op),
        .depth    (depth),
        .cur_mask (cur_mask),
        .ra_out   (ra_out),
        .stk_out  (stk_out)
    );

    eib_irq_status u_status (
        .clk      (clk),
        .reset_n  (reset_n),
        .irq      (irq),
        .op       (op),
        .cur_mask (cur_mask),
        .isr      (isr),
        .trap     (trap)
    );

    eib_read_result u_result (
        .clk      (clk),
        .reset_n  (reset_n),
        .op       (op),
        .isr      (isr),
        .cur_mask (cur_mask),
        .ra_out   (ra_out),
        .stk_out  (stk_out),
        .rdata    (rdata)
    );

endmodule

`default_nettype wire

// ==== hdl/eib_read_result.sv ====
// result stage, selects and holds the bus read data
`timescale 1ns/1ps
`default_nettype none

module eib_read_result (
    input  wire logic               clk,
    input  wire logic               reset_n,
    input  wire eib_pkg::bus_op_t   op,
    input  wire eib_pkg::irq_vec_t  isr,
    input  wire eib_pkg::irq_vec_t  cur_mask,
    input  wire eib_pkg::word_t     ra_out,
    input  wire eib_pkg::word_t     stk_out,
    output eib_pkg::word_t          rdata
);

    eib_pkg::bus_op_e kind_q;     // op kind one stage behind execute

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            kind_q <= eib_pkg::OP_NONE;
            rdata  <= '0;
        end else begin
            kind_q <= op.kind;
            case (kind_q)
                eib_pkg::OP_RA_POP: rdata <= ra_out;   // popped last cycle
                eib_pkg::OP_ISR_RD: rdata <= eib_pkg::word_t'(isr);
                eib_pkg::OP_IMR_RD: rdata <= eib_pkg::word_t'(cur_mask);
                eib_pkg::OP_STK_RD: rdata <= stk_out;
                default: begin
                end                                     // hold
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/eib_irq_status.sv ====
// interrupt status register and trap generation
// irq lines are sampled as levels, an ISR write overrides for one cycle
`timescale 1ns/1ps
`default_nettype none

module eib_irq_status (
    input  wire logic               clk,
    input  wire logic               reset_n,
    input  wire eib_pkg::irq_vec_t  irq,
    input  wire eib_pkg::bus_op_t   op,
    input  wire eib_pkg::irq_vec_t  cur_mask,
    output eib_pkg::irq_vec_t       isr,
    output logic                    trap
);

    eib_pkg::irq_vec_t irq_q;     // input sample stage

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            irq_q <= '0;
            isr   <= '0;
            trap  <= 1'b0;
        end else begin
            irq_q <= irq;
            if (op.kind == eib_pkg::OP_ISR_WR)
                isr <= op.wdata;      // write wins over the sample
            else
                isr <= irq_q;
            trap  <= |(isr & cur_mask);
        end
    end

    // a trap always traces back to a pending status bit
    a_trap_has_cause: assert property (@(posedge clk) disable iff (!reset_n)
        trap |-> ($past(isr) != '0));

endmodule

`default_nettype wire

// ==== hdl/eib_nest_stack.sv ====
// execute stage for nesting
// depth counter, return address and mask stacks, per-level scratch memory
`timescale 1ns/1ps
`default_nettype none

module eib_nest_stack (
    input  wire logic              clk,
    input  wire logic              reset_n,
    input  wire eib_pkg::bus_op_t  op,
    output eib_pkg::depth_t        depth,
    output eib_pkg::irq_vec_t      cur_mask,
    output eib_pkg::word_t         ra_out,
    output eib_pkg::word_t         stk_out
);

    eib_pkg::depth_t   depth_up;
    eib_pkg::depth_t   depth_dn;
    logic [$bits(eib_pkg::depth_t)+eib_pkg::STACK_BITS-1:0] scratch_idx;

    eib_pkg::irq_vec_t masks   [eib_pkg::MAX_DEPTH];    // one mask per level
    eib_pkg::word_t    rets    [eib_pkg::MAX_DEPTH];    // return addresses
    // all windows flattened, level in the upper index bits
    eib_pkg::word_t    scratch [eib_pkg::MAX_DEPTH * eib_pkg::STACK_SIZE];

    assign depth_up    = depth + 1'b1;
    assign depth_dn    = depth - 1'b1;
    assign scratch_idx = {depth, op.slot};
    assign cur_mask    = masks[depth];

    // depth and masks
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            depth    <= '0;
            masks[0] <= '1;               // level 0 starts fully enabled
        end else begin
            case (op.kind)
                eib_pkg::OP_RA_PUSH: begin
                    masks[depth_up] <= masks[depth];  // inherit outer mask
                    depth           <= depth_up;
                end
                eib_pkg::OP_RA_POP: begin
                    depth <= depth_dn;    // outer mask comes back with depth
                end
                eib_pkg::OP_IMR_WR: begin
                    masks[depth] <= op.wdata;
                end
                default: begin
                end
            endcase
        end
    end

    // return addresses and scratch words
    always_ff @(posedge clk) begin
        case (op.kind)
            eib_pkg::OP_RA_PUSH: begin
                rets[depth_up] <= op.wdata;
            end
            eib_pkg::OP_RA_POP: begin
                ra_out <= rets[depth];    // held until the next pop
            end
            eib_pkg::OP_STK_WR: begin
                scratch[scratch_idx] <= op.wdata;
            end
            eib_pkg::OP_STK_RD: begin
                stk_out <= scratch[scratch_idx];
            end
            default: begin
            end
        endcase
    end

    // software must not overflow or underflow the nesting stack
    a_no_overflow: assert property (@(posedge clk) disable iff (!reset_n)
        (op.kind == eib_pkg::OP_RA_PUSH) |->
            (depth != eib_pkg::depth_t'(eib_pkg::MAX_DEPTH - 1)));

    a_no_underflow: assert property (@(posedge clk) disable iff (!reset_n)
        (op.kind == eib_pkg::OP_RA_POP) |-> (depth != '0));

endmodule

`default_nettype wire

// ==== hdl/eib_bus_decode.sv ====
// bus decode stage
// turns strobe, rw and address into one registered operation
`timescale 1ns/1ps
`default_nettype none

module eib_bus_decode (
    input  wire logic            clk,
    input  wire logic            reset_n,
    input  wire logic            strobe,
    input  wire logic            rw,      // 1 means write
    input  wire eib_pkg::word_t  addr,
    input  wire eib_pkg::word_t  wdata,
    output eib_pkg::bus_op_t     op
);

    logic             in_page;
    logic             in_window;
    eib_pkg::bus_op_e next_kind;
    eib_pkg::bus_op_e kind_q;
    eib_pkg::slot_t   slot_q;
    eib_pkg::word_t   wdata_q;

    assign in_page   = (addr[31:12] == eib_pkg::PAGE_BASE);
    // below STACK_TOP by less than one window, wraps to huge values above it
    assign in_window = (eib_pkg::STACK_TOP - addr) <
                       eib_pkg::word_t'(eib_pkg::STACK_SIZE);

    always_comb begin
        next_kind = eib_pkg::OP_NONE;
        if (strobe && in_page) begin
            case (addr[11:0])
                eib_pkg::REG_RA:  next_kind = rw ? eib_pkg::OP_RA_PUSH : eib_pkg::OP_RA_POP;
                eib_pkg::REG_ISR: next_kind = rw ? eib_pkg::OP_ISR_WR  : eib_pkg::OP_ISR_RD;
                eib_pkg::REG_IMR: next_kind = rw ? eib_pkg::OP_IMR_WR  : eib_pkg::OP_IMR_RD;
                default: begin
                    if (in_window)
                        next_kind = rw ? eib_pkg::OP_STK_WR : eib_pkg::OP_STK_RD;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n)
            kind_q <= eib_pkg::OP_NONE;
        else
            kind_q <= next_kind;          // one op per strobe cycle
    end

    always_ff @(posedge clk) begin
        if (strobe) begin
            slot_q  <= eib_pkg::slot_t'(addr[eib_pkg::STACK_BITS-1:0]);
            wdata_q <= wdata;
        end
    end

    assign op = '{kind: kind_q, slot: slot_q, wdata: wdata_q};

    a_strobe_known: assert property (@(posedge clk) disable iff (!reset_n)
        !$isunknown(strobe));

endmodule

`default_nettype wire

// ==== hdl/eib_pkg.sv ====
// shared types and constants for the external interrupt block
// bus operation encoding and the decoded operation struct
`default_nettype none

package eib_pkg;

    // widths
    typedef logic [31:0] word_t;                  // bus data or address word
    typedef logic [31:0] irq_vec_t;               // one bit per interrupt line

    // scratch window and nesting geometry
    localparam int STACK_BITS = 5;                // log2 of window size in words
    localparam int STACK_SIZE = 1 << STACK_BITS;  // words per scratch window
    localparam int MAX_DEPTH  = 32;               // nesting levels

    typedef logic [$clog2(MAX_DEPTH)-1:0] depth_t;  // nesting level
    typedef logic [STACK_BITS-1:0]        slot_t;   // word within a window

    // address map, top 4 KB page
    localparam logic [19:0] PAGE_BASE = 20'hfffff;
    localparam word_t       STACK_TOP = 32'hffff_ffdf;  // highest scratch word

    localparam logic [11:0] REG_RA  = 12'hfff;    // return address push/pop
    localparam logic [11:0] REG_ISR = 12'hffe;    // interrupt status
    localparam logic [11:0] REG_IMR = 12'hffd;    // mask of current level

    // decoded bus operation
    typedef enum logic [3:0] {
        OP_NONE,
        OP_RA_PUSH,
        OP_RA_POP,
        OP_ISR_WR,
        OP_ISR_RD,
        OP_IMR_WR,
        OP_IMR_RD,
        OP_STK_WR,
        OP_STK_RD
    } bus_op_e;

    typedef struct packed {
        bus_op_e kind;    // what the access does
        slot_t   slot;    // scratch word, only for OP_STK_*
        word_t   wdata;   // write data, only for writes
    } bus_op_t;

endpackage

`default_nettype wire
